// ==== verilog/sram_pkg.sv ====
package sram_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths of the SRAM word address and the data byte
	//////////////////////////////////////////////////////////////////////

	// 256K words
	localparam int ADDR_W = 18;

	// Low byte lane only
	localparam int DATA_W = 8;

	//////////////////////////////////////////////////////////////////////
	// Command opcodes and sequencer states
	//////////////////////////////////////////////////////////////////////

	typedef enum logic
	{
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} sram_op_e;

	// Recover gives the SRAM one cycle with we_n high after a write
	typedef enum logic [1:0]
	{
		ST_IDLE    = 2'd0,
		ST_READ    = 2'd1,
		ST_WRITE   = 2'd2,
		ST_RECOVER = 2'd3
	} seq_state_e;

endpackage

// ==== verilog/sram_cmd_queue.sv ====
`timescale 1ns/1ps

module sram_cmd_queue #(
	parameter int CMD_DEPTH = 4
) (
	input  logic                          sys_clk,
	input  logic                          glbl_rst_n,
	input  logic                          cmd_valid,
	input  sram_pkg::sram_op_e            cmd_op,
	input  logic [sram_pkg::ADDR_W-1:0]   cmd_addr,
	input  logic [sram_pkg::DATA_W-1:0]   cmd_wdata,
	input  logic                          q_pop,
	output logic                          q_empty,
	output sram_pkg::sram_op_e            q_op,
	output logic [sram_pkg::ADDR_W-1:0]   q_addr,
	output logic [sram_pkg::DATA_W-1:0]   q_wdata,
	output logic                          cmd_credit
);

	import sram_pkg::*;

	localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
	localparam int CNT_W = $clog2(CMD_DEPTH + 1);

	sram_op_e            op_mem   [CMD_DEPTH];
	logic [ADDR_W-1:0]   addr_mem [CMD_DEPTH];
	logic [DATA_W-1:0]   data_mem [CMD_DEPTH];

	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    count;
	logic                pop;

	// Host only sends with credit, so a push never finds the queue full
	assign pop = q_pop && !q_empty;
	assign q_empty = (count == '0);

	assign q_op    = op_mem[rd_ptr];
	assign q_addr  = addr_mem[rd_ptr];
	assign q_wdata = data_mem[rd_ptr];

	// One credit back per command handed to the sequencer
	assign cmd_credit = pop;

	always_ff @(posedge sys_clk)
	begin
		if (cmd_valid)
		begin
			op_mem[wr_ptr]   <= cmd_op;
			addr_mem[wr_ptr] <= cmd_addr;
			data_mem[wr_ptr] <= cmd_wdata;
		end
	end

	// Pointers wrap at CMD_DEPTH, which need not be a power of two
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (cmd_valid)
				wr_ptr <= (wr_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (cmd_valid && !pop)
				count <= count + 1'b1;
			else if (pop && !cmd_valid)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== verilog/sram_cycle_timer.sv ====
`timescale 1ns/1ps

module sram_cycle_timer (
	input  logic         sys_clk,
	input  logic         glbl_rst_n,
	input  logic         tmr_load,
	input  logic [3:0]   tmr_count,
	output logic         tmr_done
);

	logic [3:0]   cnt;
	logic         active;

	// Done in the last cycle of the count
	assign tmr_done = active && (cnt == 4'd0);

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			cnt    <= 4'd0;
			active <= 1'b0;
		end
		else if (tmr_load)
		begin
			cnt    <= tmr_count - 4'd1;
			active <= 1'b1;
		end
		else if (active)
		begin
			if (cnt == 4'd0)
				active <= 1'b0;
			else
				cnt <= cnt - 4'd1;
		end
	end

endmodule

// ==== verilog/sram_seq_fsm.sv ====
`timescale 1ns/1ps

module sram_seq_fsm #(
	parameter int WAIT_STATES = 2
) (
	input  logic                          sys_clk,
	input  logic                          glbl_rst_n,
	input  logic                          q_empty,
	input  sram_pkg::sram_op_e            q_op,
	input  logic [sram_pkg::ADDR_W-1:0]   q_addr,
	input  logic [sram_pkg::DATA_W-1:0]   q_wdata,
	output logic                          q_pop,
	input  logic                          tmr_done,
	output logic                          tmr_load,
	output logic [3:0]                    tmr_count,
	output logic                          rd_flag,
	output logic                          rd_capture,
	output logic                          wr_start,
	output logic                          wr_done,
	output logic                          wr_en_n,
	output logic [sram_pkg::ADDR_W-1:0]   acc_addr,
	output logic [sram_pkg::DATA_W-1:0]   acc_wdata
);

	import sram_pkg::*;

	seq_state_e state;
	seq_state_e state_nxt;

	//////////////////////////////////////////////////////////////////////
	// State register and next state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:
			begin
				if (!q_empty)
					state_nxt = (q_op == OP_WRITE) ? ST_WRITE : ST_READ;
			end
			ST_READ:
			begin
				if (tmr_done)
					state_nxt = ST_IDLE;
			end
			ST_WRITE:
			begin
				if (tmr_done)
					state_nxt = ST_RECOVER;
			end
			ST_RECOVER:
			begin
				state_nxt = ST_IDLE;
			end
			default:
			begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Queue, timer and pin block strobes
	//////////////////////////////////////////////////////////////////////

	assign q_pop = (state == ST_IDLE) && !q_empty;

	// Timer starts with the pop, so it runs over the whole read or write
	assign tmr_load  = q_pop;
	assign tmr_count = 4'(WAIT_STATES);

	assign rd_flag    = (state == ST_READ);
	assign rd_capture = rd_flag && tmr_done;

	assign wr_start = q_pop && (q_op == OP_WRITE);
	assign wr_done  = (state == ST_RECOVER);
	assign wr_en_n  = (state != ST_WRITE);

	// Address and data stay put until the next pop
	always_ff @(posedge sys_clk)
	begin
		if (q_pop)
		begin
			acc_addr  <= q_addr;
			acc_wdata <= q_wdata;
		end
	end

endmodule

// ==== verilog/sram_pin_ctrl.sv ====
`timescale 1ns/1ps

module sram_pin_ctrl (
	input  logic                          sys_clk,
	input  logic                          glbl_rst_n,
	input  logic                          rd_flag,
	input  logic                          rd_capture,
	input  logic                          wr_start,
	input  logic                          wr_done,
	input  logic                          wr_en_n,
	input  logic [sram_pkg::ADDR_W-1:0]   acc_addr,
	input  logic [sram_pkg::DATA_W-1:0]   acc_wdata,
	output logic                          rsp_valid,
	output logic [sram_pkg::DATA_W-1:0]   rsp_rdata,
	output logic                          sram_ce1_n,
	output logic                          sram_ce2,
	output logic                          sram_oe_n,
	output logic                          sram_bhen_n,
	output logic                          sram_blen_n,
	output logic                          sram_we_n,
	output logic [sram_pkg::ADDR_W-1:0]   sram_addr,
	input  logic [sram_pkg::DATA_W-1:0]   sram_in_data,
	output logic [sram_pkg::DATA_W-1:0]   sram_out_data,
	output logic                          sram_out_en
);

	import sram_pkg::*;

	logic                wr_flag;
	logic [DATA_W-1:0]   rd_stage1;
	logic                rd_valid1;

	// Address only driven while an access is active
	assign sram_addr     = (rd_flag || wr_flag) ? acc_addr : '0;
	assign sram_out_en   = wr_flag;
	assign sram_out_data = wr_flag ? acc_wdata : '0;
	assign sram_we_n     = wr_en_n;

	// Upper byte lane unused
	assign sram_bhen_n = 1'b1;

	// Write flag covers the write cycles and the recover cycle
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
			wr_flag <= 1'b0;
		else if (wr_done)
			wr_flag <= 1'b0;
		else if (wr_start)
			wr_flag <= 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Registered chip enables and output enable
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			sram_ce1_n  <= 1'b1;
			sram_ce2    <= 1'b0;
			sram_oe_n   <= 1'b1;
			sram_blen_n <= 1'b1;
		end
		else if (rd_flag)
		begin
			sram_ce1_n  <= 1'b0;
			sram_ce2    <= 1'b1;
			sram_oe_n   <= 1'b0;
			sram_blen_n <= 1'b0;
		end
		else if (wr_flag)
		begin
			sram_ce1_n  <= 1'b0;
			sram_ce2    <= 1'b1;
			sram_oe_n   <= 1'b1;
			sram_blen_n <= 1'b0;
		end
		else
		begin
			sram_ce1_n  <= 1'b1;
			sram_ce2    <= 1'b0;
			sram_oe_n   <= 1'b1;
			sram_blen_n <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Two-stage read capture
	//////////////////////////////////////////////////////////////////////

	// Data stages run freely, the valid bits mark the read byte
	always_ff @(posedge sys_clk)
	begin
		rd_stage1 <= sram_in_data;
		rsp_rdata <= rd_stage1;
	end

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			rd_valid1 <= 1'b0;
			rsp_valid <= 1'b0;
		end
		else
		begin
			rd_valid1 <= rd_capture;
			rsp_valid <= rd_valid1;
		end
	end

endmodule

// ==== verilog/sram_ctrl_top.sv ====
`timescale 1ns/1ps

module sram_ctrl_top #(
	parameter int CMD_DEPTH   = 4,
	parameter int WAIT_STATES = 2
) (
	input  logic                          sys_clk,
	input  logic                          glbl_rst_n,

	// Host commands and responses
	input  logic                          cmd_valid,
	input  sram_pkg::sram_op_e            cmd_op,
	input  logic [sram_pkg::ADDR_W-1:0]   cmd_addr,
	input  logic [sram_pkg::DATA_W-1:0]   cmd_wdata,
	output logic                          cmd_credit,
	output logic                          rsp_valid,
	output logic [sram_pkg::DATA_W-1:0]   rsp_rdata,

	// SRAM pins
	output logic                          sram_ce1_n,
	output logic                          sram_ce2,
	output logic                          sram_oe_n,
	output logic                          sram_bhen_n,
	output logic                          sram_blen_n,
	output logic                          sram_we_n,
	output logic [sram_pkg::ADDR_W-1:0]   sram_addr,
	input  logic [sram_pkg::DATA_W-1:0]   sram_in_data,
	output logic [sram_pkg::DATA_W-1:0]   sram_out_data,
	output logic                          sram_out_en
);

	import sram_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Internal connections
	//////////////////////////////////////////////////////////////////////

	// Queue head
	logic                q_empty;
	logic                q_pop;
	sram_op_e            q_op;
	logic [ADDR_W-1:0]   q_addr;
	logic [DATA_W-1:0]   q_wdata;

	// Wait-state timer
	logic                tmr_load;
	logic [3:0]          tmr_count;
	logic                tmr_done;

	// Access strobes to the pin block
	logic                rd_flag;
	logic                rd_capture;
	logic                wr_start;
	logic                wr_done;
	logic                wr_en_n;
	logic [ADDR_W-1:0]   acc_addr;
	logic [DATA_W-1:0]   acc_wdata;

	sram_cmd_queue #(
		.CMD_DEPTH (CMD_DEPTH)
	) u_cmd_queue (
		.sys_clk    (sys_clk),
		.glbl_rst_n (glbl_rst_n),
		.cmd_valid  (cmd_valid),
		.cmd_op     (cmd_op),
		.cmd_addr   (cmd_addr),
		.cmd_wdata  (cmd_wdata),
		.q_pop      (q_pop),
		.q_empty    (q_empty),
		.q_op       (q_op),
		.q_addr     (q_addr),
		.q_wdata    (q_wdata),
		.cmd_credit (cmd_credit)
	);

	sram_seq_fsm #(
		.WAIT_STATES (WAIT_STATES)
	) u_seq_fsm (
		.sys_clk    (sys_clk),
		.glbl_rst_n (glbl_rst_n),
		.q_empty    (q_empty),
		.q_op       (q_op),
		.q_addr     (q_addr),
		.q_wdata    (q_wdata),
		.q_pop      (q_pop),
		.tmr_done   (tmr_done),
		.tmr_load   (tmr_load),
		.tmr_count  (tmr_count),
		.rd_flag    (rd_flag),
		.rd_capture (rd_capture),
		.wr_start   (wr_start),
		.wr_done    (wr_done),
		.wr_en_n    (wr_en_n),
		.acc_addr   (acc_addr),
		.acc_wdata  (acc_wdata)
	);

	sram_cycle_timer u_cycle_timer (
		.sys_clk    (sys_clk),
		.glbl_rst_n (glbl_rst_n),
		.tmr_load   (tmr_load),
		.tmr_count  (tmr_count),
		.tmr_done   (tmr_done)
	);

	sram_pin_ctrl u_pin_ctrl (
		.sys_clk       (sys_clk),
		.glbl_rst_n    (glbl_rst_n),
		.rd_flag       (rd_flag),
		.rd_capture    (rd_capture),
		.wr_start      (wr_start),
		.wr_done       (wr_done),
		.wr_en_n       (wr_en_n),
		.acc_addr      (acc_addr),
		.acc_wdata     (acc_wdata),
		.rsp_valid     (rsp_valid),
		.rsp_rdata     (rsp_rdata),
		.sram_ce1_n    (sram_ce1_n),
		.sram_ce2      (sram_ce2),
		.sram_oe_n     (sram_oe_n),
		.sram_bhen_n   (sram_bhen_n),
		.sram_blen_n   (sram_blen_n),
		.sram_we_n     (sram_we_n),
		.sram_addr     (sram_addr),
		.sram_in_data  (sram_in_data),
		.sram_out_data (sram_out_data),
		.sram_out_en   (sram_out_en)
	);

endmodule

// ==== test/sram_async_model.sv ====
`timescale 1ns/1ps

module sram_async_model (
	input  logic                          ce1_n,
	input  logic                          ce2,
	input  logic                          oe_n,
	input  logic                          we_n,
	input  logic                          blen_n,
	input  logic [sram_pkg::ADDR_W-1:0]   addr,
	input  logic [sram_pkg::DATA_W-1:0]   data_in,
	output logic [sram_pkg::DATA_W-1:0]   data_out
);

	import sram_pkg::*;

	localparam int WORDS = 1 << ADDR_W;

	// Low byte lane only, the upper lane is not modeled
	logic [DATA_W-1:0]   mem [WORDS];
	logic                selected;

	assign selected = !ce1_n && ce2 && !blen_n;

	// Read path is combinational, zero when the chip is not driving
	assign data_out = (selected && !oe_n && we_n) ? mem[addr] : '0;

	initial
	begin
		for (int i = 0; i < WORDS; i++)
			mem[i] = '0;
	end

	// Byte is taken on the rising edge of we_n
	always @(posedge we_n)
	begin
		if (selected)
			mem[addr] = data_in;
	end

endmodule

// ==== test/tb_sram_ctrl.sv ====
`timescale 1ns/1ps

module tb_sram_ctrl;

	import sram_pkg::*;

	localparam int CLK_PERIOD  = 100;
	localparam int CMD_DEPTH   = 4;
	localparam int WAIT_STATES = 2;
	localparam int MEM_WORDS   = 1 << ADDR_W;
	localparam int RAND_CMDS   = 64;
	localparam int ORDER_CMDS  = 6;

	// Two commands, a full queue of writes, the order test, random traffic
	localparam int TOTAL_CMDS      = 2 + CMD_DEPTH + 2 * ORDER_CMDS + RAND_CMDS;
	localparam int WATCHDOG_CYCLES = TOTAL_CMDS * (WAIT_STATES + 6) + 400;
	localparam int DRAIN_LIMIT     = CMD_DEPTH * (WAIT_STATES + 6) + 20;
	localparam int CREDIT_LIMIT    = (WAIT_STATES + 6) + 20;

	localparam logic [ADDR_W-1:0] SINGLE_ADDR = 18'h1_2345;
	localparam logic [ADDR_W-1:0] CREDIT_BASE = 18'h0_0100;
	localparam logic [ADDR_W-1:0] ORDER_BASE  = 18'h2_0040;
	localparam logic [ADDR_W-1:0] RAND_BASE   = 18'h3_ff00;

	logic                sys_clk;
	logic                glbl_rst_n;
	logic                cmd_valid;
	sram_op_e            cmd_op;
	logic [ADDR_W-1:0]   cmd_addr;
	logic [DATA_W-1:0]   cmd_wdata;
	logic                cmd_credit;
	logic                rsp_valid;
	logic [DATA_W-1:0]   rsp_rdata;
	logic                sram_ce1_n;
	logic                sram_ce2;
	logic                sram_oe_n;
	logic                sram_bhen_n;
	logic                sram_blen_n;
	logic                sram_we_n;
	logic [ADDR_W-1:0]   sram_addr;
	logic [DATA_W-1:0]   sram_in_data;
	logic [DATA_W-1:0]   sram_out_data;
	logic                sram_out_en;

	// Host view of the SRAM contents
	logic [DATA_W-1:0]   mirror [MEM_WORDS];
	logic [DATA_W-1:0]   exp_q [$];
	logic [31:0]         lfsr_state;

	int error_count      = 0;
	int check_count      = 0;
	int tests_run        = 0;
	int credits_returned = 0;
	int cmds_sent        = 0;
	int rsp_count        = 0;

	sram_ctrl_top #(
		.CMD_DEPTH   (CMD_DEPTH),
		.WAIT_STATES (WAIT_STATES)
	) u_sram_ctrl_top (
		.sys_clk       (sys_clk),
		.glbl_rst_n    (glbl_rst_n),
		.cmd_valid     (cmd_valid),
		.cmd_op        (cmd_op),
		.cmd_addr      (cmd_addr),
		.cmd_wdata     (cmd_wdata),
		.cmd_credit    (cmd_credit),
		.rsp_valid     (rsp_valid),
		.rsp_rdata     (rsp_rdata),
		.sram_ce1_n    (sram_ce1_n),
		.sram_ce2      (sram_ce2),
		.sram_oe_n     (sram_oe_n),
		.sram_bhen_n   (sram_bhen_n),
		.sram_blen_n   (sram_blen_n),
		.sram_we_n     (sram_we_n),
		.sram_addr     (sram_addr),
		.sram_in_data  (sram_in_data),
		.sram_out_data (sram_out_data),
		.sram_out_en   (sram_out_en)
	);

	sram_async_model u_sram_model (
		.ce1_n    (sram_ce1_n),
		.ce2      (sram_ce2),
		.oe_n     (sram_oe_n),
		.we_n     (sram_we_n),
		.blen_n   (sram_blen_n),
		.addr     (sram_addr),
		.data_in  (sram_out_data),
		.data_out (sram_in_data)
	);

	initial
	begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
		return bits;
	endfunction

	function automatic int credits_free();
		return CMD_DEPTH + credits_returned - cmds_sent;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		assert (got === expected)
		else
		begin
			$display("error %s: got %0h expected %0h", name, got, expected);
			error_count++;
		end
	endtask

	// Leaves cmd_valid high, so the next call can follow in the next cycle
	task automatic issue_command(input sram_op_e op, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		int waited;
		waited = 0;
		@(negedge sys_clk);
		while (credits_free() == 0 && waited < CREDIT_LIMIT)
		begin
			cmd_valid = 1'b0;
			@(negedge sys_clk);
			waited++;
		end
		check_count++;
		assert (credits_free() > 0)
		else
		begin
			$display("no credit came back within %0d cycles", waited);
			error_count++;
		end
		if (credits_free() > 0)
		begin
			cmd_valid = 1'b1;
			cmd_op    = op;
			cmd_addr  = addr;
			cmd_wdata = data;
			cmds_sent++;
			if (op == OP_WRITE)
				mirror[addr] = data;
			else
				exp_q.push_back(mirror[addr]);
		end
	endtask

	task automatic drain_responses(input string test_name);
		int waited;
		waited = 0;
		@(negedge sys_clk);
		cmd_valid = 1'b0;
		while ((exp_q.size() != 0 || credits_free() != CMD_DEPTH) && waited < DRAIN_LIMIT)
		begin
			@(negedge sys_clk);
			waited++;
		end
		check_count++;
		assert (exp_q.size() == 0 && credits_free() == CMD_DEPTH)
		else
		begin
			$display("%s did not drain, %0d reads still outstanding", test_name, exp_q.size());
			error_count++;
		end
		// Idle cycles so a stray response still shows up
		repeat (6) @(negedge sys_clk);
	endtask

	task automatic finish_test(input string name, input int start_errors);
		tests_run++;
		if (error_count == start_errors)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, error_count - start_errors);
	endtask

	// Outputs sampled mid-cycle, well away from the rising edge
	always @(negedge sys_clk)
	begin
		logic [DATA_W-1:0] expected;
		if (glbl_rst_n)
		begin
			if (cmd_credit)
				credits_returned++;
			// Write data bus driven and upper lane off while we_n is low
			if (!sram_we_n)
			begin
				compare_value("sram_out_en", 32'(sram_out_en), 32'h1);
				compare_value("sram_bhen_n", 32'(sram_bhen_n), 32'h1);
			end
			if (rsp_valid)
			begin
				rsp_count++;
				check_count++;
				assert (exp_q.size() != 0)
				else
				begin
					$display("response arrived with no read pending, data %0h", rsp_rdata);
					error_count++;
				end
				if (exp_q.size() != 0)
				begin
					expected = exp_q.pop_front();
					compare_value("rsp_rdata", 32'(rsp_rdata), 32'(expected));
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset_idle();
		int start_errors;
		start_errors = error_count;
		repeat (4)
		begin
			@(negedge sys_clk);
			compare_value("sram_ce1_n", 32'(sram_ce1_n), 32'h1);
			compare_value("sram_ce2", 32'(sram_ce2), 32'h0);
			compare_value("sram_oe_n", 32'(sram_oe_n), 32'h1);
			compare_value("sram_we_n", 32'(sram_we_n), 32'h1);
			compare_value("sram_bhen_n", 32'(sram_bhen_n), 32'h1);
			compare_value("sram_blen_n", 32'(sram_blen_n), 32'h1);
			compare_value("sram_out_en", 32'(sram_out_en), 32'h0);
			compare_value("sram_addr", 32'(sram_addr), 32'h0);
			compare_value("rsp_valid", 32'(rsp_valid), 32'h0);
			compare_value("cmd_credit", 32'(cmd_credit), 32'h0);
		end
		finish_test("test_reset_idle", start_errors);
	endtask

	task automatic test_single_write_read();
		int start_errors;
		int start_rsp;
		start_errors = error_count;
		start_rsp    = rsp_count;
		issue_command(OP_WRITE, SINGLE_ADDR, 8'h5a);
		issue_command(OP_READ, SINGLE_ADDR, 8'h00);
		drain_responses("test_single_write_read");
		compare_value("rsp_valid pulses", rsp_count - start_rsp, 1);
		compare_value("sram mem", 32'(u_sram_model.mem[SINGLE_ADDR]), 32'h5a);
		finish_test("test_single_write_read", start_errors);
	endtask

	task automatic test_credit_limit();
		int start_errors;
		int start_credits;
		start_errors  = error_count;
		start_credits = credits_returned;
		compare_value("free credits", credits_free(), CMD_DEPTH);
		// Whole initial credit spent back to back
		for (int i = 0; i < CMD_DEPTH; i++)
		begin
			issue_command(OP_WRITE, CREDIT_BASE + ADDR_W'(i), 8'hc0 + 8'(i));
		end
		drain_responses("test_credit_limit");
		compare_value("cmd_credit pulses", credits_returned - start_credits, CMD_DEPTH);
		compare_value("free credits", credits_free(), CMD_DEPTH);
		// Every write of the full queue reached the SRAM
		for (int i = 0; i < CMD_DEPTH; i++)
			compare_value("sram mem", 32'(u_sram_model.mem[CREDIT_BASE + ADDR_W'(i)]),
				32'(8'hc0 + 8'(i)));
		finish_test("test_credit_limit", start_errors);
	endtask

	task automatic test_read_order();
		int start_errors;
		int start_rsp;
		start_errors = error_count;
		start_rsp    = rsp_count;
		for (int i = 0; i < ORDER_CMDS; i++)
			issue_command(OP_WRITE, ORDER_BASE + ADDR_W'(i * 3), 8'(8'h11 * (i + 1)));
		// Reverse order, so any reordering shows in the data
		for (int i = 0; i < ORDER_CMDS; i++)
			issue_command(OP_READ, ORDER_BASE + ADDR_W'((ORDER_CMDS - 1 - i) * 3), 8'h00);
		drain_responses("test_read_order");
		compare_value("rsp_valid pulses", rsp_count - start_rsp, ORDER_CMDS);
		finish_test("test_read_order", start_errors);
	endtask

	task automatic test_random_traffic();
		int            start_errors;
		int            start_rsp;
		int            reads;
		logic [31:0]   r;
		logic          op_bit;
		logic [3:0]    offset;
		logic [7:0]    data;
		start_errors = error_count;
		start_rsp    = rsp_count;
		reads        = 0;
		// Small window, so reads hit both written and untouched bytes
		for (int i = 0; i < RAND_CMDS; i++)
		begin
			r      = random_bits(1);
			op_bit = r[0];
			r      = random_bits(4);
			offset = r[3:0];
			r      = random_bits(8);
			data   = r[7:0];
			if (!op_bit)
				reads++;
			issue_command(op_bit ? OP_WRITE : OP_READ, RAND_BASE + ADDR_W'(offset), data);
		end
		drain_responses("test_random_traffic");
		compare_value("rsp_valid pulses", rsp_count - start_rsp, reads);
		finish_test("test_random_traffic", start_errors);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		glbl_rst_n = 1'b0;
		cmd_valid  = 1'b0;
		cmd_op     = OP_READ;
		cmd_addr   = '0;
		cmd_wdata  = '0;
		lfsr_state = 32'hf87a;
		for (int i = 0; i < MEM_WORDS; i++)
			mirror[i] = '0;

		repeat (4) @(posedge sys_clk);
		@(negedge sys_clk);
		glbl_rst_n = 1'b1;

		test_reset_idle();
		test_single_write_read();
		test_credit_limit();
		test_read_order();
		test_random_traffic();

		$display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
		if (error_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
verilog/sram_pkg.sv
verilog/sram_cmd_queue.sv
verilog/sram_cycle_timer.sv
verilog/sram_seq_fsm.sv
verilog/sram_pin_ctrl.sv
verilog/sram_ctrl_top.sv
test/sram_async_model.sv
test/tb_sram_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f verilog.f --top-module tb_sram_ctrl -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi

if ! grep -q "TESTS PASSED" sim.log; then
	echo "simulation log holds no result line"
	exit 1
fi

exit 0
